/* src.f */
rtl/hf_rx_pkg.sv
rtl/hf_apb_pkg.sv
rtl/hf_rx_ctrl.sv
rtl/am_hysteresis.sv
rtl/iq_correlator.sv
rtl/ssp_serializer.sv
rtl/hf_rx_xcorr_top.sv
+incdir+tb
tb/tb_hf_rx_xcorr.sv

/* tb/tb_hf_rx_tasks.svh */
/*
 * Tasks of the correlator testbench, included inside the testbench module.
 * All tasks run from the one sequencing process and drive 2 ns after an edge.
 */

// --------------------------------------------------
// Checking and bus access
// --------------------------------------------------

task automatic check_eq(
    input logic [31:0] got,
    input logic [31:0] exp,
    input string       msg
);
    if (got !== exp)
    begin
        $display("MISMATCH at %0t: %s, got 0x%0h, expected 0x%0h", $time, msg, got, exp);
        $display("Result: FAILED");
        $fatal(1, "Value check failed");
    end
endtask

// Returns 2 ns after the edge on which the write lands
task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
    @(posedge adc_clk);
    #2;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b1;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    @(posedge adc_clk);
    #2;
    apb_req.penable = 1'b1;
    @(posedge adc_clk);
    #2;
    apb_req = '0;
endtask

task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
    @(posedge adc_clk);
    #2;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
    apb_req.paddr   = addr;
    apb_req.pwdata  = '0;
    @(posedge adc_clk);
    #2;
    apb_req.penable = 1'b1;
    // Sample in the middle of the access phase, away from both edges
    #8;
    data = apb_rsp.prdata;
    err  = apb_rsp.pslverr;
    check_eq(apb_rsp.pready, 1'b1, "pready in access phase");
    @(posedge adc_clk);
    #2;
    apb_req = '0;
endtask

task automatic check_reg(input logic [3:0] addr, input logic [31:0] exp, input string msg);
    logic [31:0] rd;
    logic        err;
    apb_read(addr, rd, err);
    check_eq(rd, exp, msg);
    check_eq(err, 1'b0, {msg, " pslverr"});
endtask

// --------------------------------------------------
// Stimulus, capture and reference model
// --------------------------------------------------

function automatic logic [7:0] next_sample(input int kind);
    logic [7:0] s;
    case (kind)
        KIND_ONES:  s = 8'hFF;
        KIND_ZEROS: s = 8'h00;
        KIND_MID:   s = 8'h80;
        default:    s = 8'($random(seed));
    endcase
    return s;
endfunction

// The reader report byte is the top 8 bits of the ACC_W wide sum
function automatic logic [7:0] sum_byte(input int sum);
    logic [31:0] v;
    v = sum;
    return v[ACC_W-1 -: 8];
endfunction

// Snoop report keeps only the top 7 bits
function automatic logic [6:0] sum_top7(input int sum);
    logic [31:0] v;
    v = sum;
    return v[ACC_W-1 -: 7];
endfunction

// Each sample is held for hold cycles, one step per sample.
// I weight is +1 while step bit 3 is clear, Q is +1 while bits 3 and 2 agree
task automatic drive_windows(input int n_win, input int hold);
    logic [7:0] s;
    logic [5:0] pos;
    int         w;
    int         st;
    for (w = 0; w < n_win; w++)
    begin
        sum_i[w] = 0;
        sum_q[w] = 0;
        for (st = 0; st < 64; st++)
        begin
            s     = next_sample(win_kind[w]);
            pos   = 6'(st);
            adc_d = s;
            sum_i[w] += pos[3] ? -int'(s) : int'(s);
            sum_q[w] += (pos[3] == pos[2]) ? int'(s) : -int'(s);
            repeat (hold)
            begin
                @(posedge adc_clk);
                #2;
            end
        end
    end
endtask

// One report starts at the rise of the i frame, bits are taken at falling ssp_clk
task automatic capture_pair(output logic [15:0] word);
    logic [15:0] sh;
    int          b;
    sh = '0;
    @(posedge ssp_frame);
    for (b = 0; b < 16; b++)
    begin
        @(negedge ssp_clk);
        sh = {sh[14:0], ssp_din};
    end
    word = sh;
endtask

// The first report after enable holds the empty accumulators
task automatic capture_windows(input int n_win);
    logic [15:0] dummy;
    int          w;
    capture_pair(dummy);
    for (w = 0; w < n_win; w++)
    begin
        capture_pair(got_pair[w]);
    end
endtask

// Each report has two frame rises, so the last report opens at rise 2*n_win+1
task automatic read_status_after(input int n_win);
    logic [31:0] rd;
    logic        err;
    repeat (2 * n_win + 1) @(posedge ssp_frame);
    apb_read(hf_apb_pkg::REG_PAIR, rd, err);
    check_eq(err, 1'b0, "REG_PAIR pslverr");
    reg_pair = rd[15:0];
    apb_read(hf_apb_pkg::REG_COUNT, rd, err);
    check_eq(err, 1'b0, "REG_COUNT pslverr");
    cnt_end = rd[15:0];
endtask

// Enables the mode, runs n_win reported windows and checks the status registers
task automatic run_windows(input logic [2:0] mode_bits, input int n_win, input int hold);
    logic [31:0] rd;
    logic        err;
    apb_write(hf_apb_pkg::REG_CTRL, 32'h0);
    apb_read(hf_apb_pkg::REG_COUNT, rd, err);
    check_eq(err, 1'b0, "REG_COUNT pslverr before enable");
    cnt_start = rd[15:0];
    apb_write(hf_apb_pkg::REG_CTRL, {29'h0, mode_bits});
    fork
        drive_windows(n_win + 1, hold);
        capture_windows(n_win);
        read_status_after(n_win);
    join
    apb_write(hf_apb_pkg::REG_CTRL, 32'h0);
    check_eq(cnt_end, 16'(cnt_start + n_win + 1), "REG_COUNT windows since enable");
    check_eq(reg_pair, got_pair[n_win-1], "REG_PAIR against last serial pair");
endtask

// --------------------------------------------------
// Tests
// --------------------------------------------------

task automatic test_registers();
    logic [2:0]  vals [0:5] = '{3'b001, 3'b011, 3'b101, 3'b111, 3'b010, 3'b000};
    logic [31:0] rd;
    logic        err;
    int          k;
    check_reg(hf_apb_pkg::REG_CTRL, 32'h0, "CTRL after reset");
    check_reg(hf_apb_pkg::REG_COUNT, 32'h0, "COUNT after reset");
    check_reg(hf_apb_pkg::REG_PAIR, 32'h0, "PAIR after reset");
    check_eq({pwr_hi, ssp_clk, ssp_frame, ssp_din}, 4'b0000, "outputs after reset");
    for (k = 0; k < 6; k++)
    begin
        apb_write(hf_apb_pkg::REG_CTRL, {29'h0, vals[k]});
        check_reg(hf_apb_pkg::REG_CTRL, {29'h0, vals[k]}, "CTRL read back");
        check_eq(pwr_hi, vals[k][0] && !vals[k][1], "pwr_hi from enable and snoop");
    end
    apb_read(4'hC, rd, err);
    check_eq(err, 1'b1, "pslverr on unmapped offset");
    check_eq(rd, 32'h0, "data on unmapped offset");
endtask

task automatic test_reader_848();
    int w;
    for (w = 0; w < 7; w++)
        win_kind[w] = KIND_RAND;
    run_windows(3'b101, 6, 1);
    for (w = 0; w < 6; w++)
    begin
        check_eq(got_pair[w], {sum_byte(sum_i[w]), sum_byte(sum_q[w])},
                 $sformatf("848 kHz window %0d pair", w));
    end
endtask

// Samples are held for two cycles so each step sees one value
task automatic test_reader_424();
    int w;
    for (w = 0; w < 5; w++)
        win_kind[w] = KIND_RAND;
    run_windows(3'b001, 4, 2);
    for (w = 0; w < 4; w++)
    begin
        check_eq(got_pair[w], {sum_byte(sum_i[w]), sum_byte(sum_q[w])},
                 $sformatf("424 kHz window %0d pair", w));
    end
endtask

task automatic test_snoop();
    int   kinds [0:6] = '{KIND_ONES, KIND_ZEROS, KIND_ONES, KIND_ONES,
                          KIND_ZEROS, KIND_ONES, KIND_ONES};
    logic lvl   [0:6];
    int   w;
    for (w = 0; w < 7; w++)
    begin
        win_kind[w] = kinds[w];
        lvl[w]      = (kinds[w] == KIND_ONES);
    end
    run_windows(3'b111, 6, 1);
    for (w = 0; w < 6; w++)
    begin
        check_eq(got_pair[w][15:9], sum_top7(sum_i[w]), $sformatf("snoop i top %0d", w));
        check_eq(got_pair[w][7:1], sum_top7(sum_q[w]), $sformatf("snoop q top %0d", w));
        check_eq(got_pair[w][0], lvl[w], $sformatf("snoop mid-window AM %0d", w));
        // Window 0 starts from the level left by earlier tests
        if (w > 0)
            check_eq(got_pair[w][8], lvl[w-1], $sformatf("snoop window-end AM %0d", w));
    end
endtask

// Mid-scale samples never move the slicer, so only the timeout can release it
task automatic test_slicer_timeout();
    int kinds [0:5] = '{KIND_ONES, KIND_ZEROS, KIND_ZEROS, KIND_MID, KIND_MID, KIND_MID};
    int w;
    for (w = 0; w < 6; w++)
        win_kind[w] = kinds[w];
    run_windows(3'b111, 5, 1);
    check_eq(got_pair[0][0], 1'b1, "AM high before the gap");
    check_eq(got_pair[1][0], 1'b0, "AM low in the gap");
    check_eq(got_pair[4][0], 1'b1, "AM released by the low timeout");
    check_eq(got_pair[4][8], 1'b1, "AM high at window end after release");
endtask

task automatic test_disable();
    logic [31:0] rd;
    logic        err;
    logic [15:0] cnt_off;
    int          k;
    apb_write(hf_apb_pkg::REG_CTRL, 32'h5);
    repeat (100) @(posedge adc_clk);
    apb_write(hf_apb_pkg::REG_CTRL, 32'h0);
    apb_read(hf_apb_pkg::REG_COUNT, rd, err);
    check_eq(err, 1'b0, "REG_COUNT pslverr after disable");
    cnt_off = rd[15:0];
    for (k = 0; k < 200; k++)
    begin
        @(posedge adc_clk);
        #10;
        check_eq({ssp_clk, ssp_frame, ssp_din}, 3'b000, "SSP idle while disabled");
    end
    check_eq(pwr_hi, 1'b0, "pwr_hi while disabled");
    check_reg(hf_apb_pkg::REG_COUNT, {16'h0, cnt_off}, "COUNT frozen while disabled");
endtask

/* tb/tb_hf_rx_xcorr.sv */
/*
 * Directed testbench for the HF receive correlator top level.
 * LOW_TIMEOUT is cut to 63 so the slicer release shows within a few windows.
 * The run stops at the first failing check.
 */

`timescale 1ns/100ps

module tb_hf_rx_xcorr;

    localparam int ACC_W       = 14;
    localparam int LOW_TIMEOUT = 63;
    localparam int MAX_CYCLES  = 40000;
    localparam int MAX_WIN     = 16;

    // Kind of sample used throughout one window
    localparam int KIND_RAND  = 0;
    localparam int KIND_ONES  = 1;
    localparam int KIND_ZEROS = 2;
    localparam int KIND_MID   = 3;

    logic                 adc_clk;
    logic                 rst_n;
    hf_apb_pkg::apb_req_t apb_req;
    hf_apb_pkg::apb_rsp_t apb_rsp;
    hf_rx_pkg::sample_t   adc_d;
    logic                 ssp_clk;
    logic                 ssp_frame;
    logic                 ssp_din;
    logic                 pwr_hi;

    integer seed;
    int     cycle_cnt;

    // Stimulus kinds, model sums and captured results of the last run
    int          win_kind [0:MAX_WIN-1];
    int          sum_i    [0:MAX_WIN-1];
    int          sum_q    [0:MAX_WIN-1];
    logic [15:0] got_pair [0:MAX_WIN-1];
    logic [15:0] reg_pair;
    logic [15:0] cnt_start;
    logic [15:0] cnt_end;

    `include "tb_hf_rx_tasks.svh"

    // --------------------------------------------------
    // DUT
    // --------------------------------------------------

    hf_rx_xcorr_top #(
        .ACC_W       (ACC_W),
        .LOW_TIMEOUT (LOW_TIMEOUT)
    ) i_dut (
        .adc_clk   (adc_clk),
        .rst_n     (rst_n),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .adc_d     (adc_d),
        .ssp_clk   (ssp_clk),
        .ssp_frame (ssp_frame),
        .ssp_din   (ssp_din),
        .pwr_hi    (pwr_hi)
    );

    // --------------------------------------------------
    // Clock and run limit
    // --------------------------------------------------

    // 50 MHz stand-in for adc_clk
    initial
    begin
        adc_clk = 1'b0;
        forever #10 adc_clk = ~adc_clk;
    end

    // About 3000 cycles are needed, so the limit leaves a wide margin
    always @(posedge adc_clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES)
        begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------

    initial
    begin
        seed      = 77526;
        cycle_cnt = 0;
        rst_n     = 1'b0;
        apb_req   = '0;
        adc_d     = '0;

        // Reset is released just after an edge, like all other inputs
        repeat (16) @(posedge adc_clk);
        #2;
        rst_n = 1'b1;

        test_registers();
        test_reader_848();
        test_reader_424();
        test_snoop();
        test_slicer_timeout();
        test_disable();

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* rtl/hf_rx_xcorr_top.sv */
/*
 * Receive path top level, clocked by adc_clk alone.
 * ACC_W sets the correlator sum width and LOW_TIMEOUT the AM release.
 */

`timescale 1ns/100ps

module hf_rx_xcorr_top #(
    parameter int ACC_W       = 14,
    parameter int LOW_TIMEOUT = 4095
) (
    input  logic                 adc_clk,
    input  logic                 rst_n,
    input  hf_apb_pkg::apb_req_t apb_req,
    output hf_apb_pkg::apb_rsp_t apb_rsp,
    input  hf_rx_pkg::sample_t   adc_d,
    output logic                 ssp_clk,
    output logic                 ssp_frame,
    output logic                 ssp_din,
    output logic                 pwr_hi
);

    hf_rx_pkg::rx_mode_t   mode;
    hf_rx_pkg::win_phase_t phase;
    hf_rx_pkg::corr_pair_t pair;
    logic                  pair_valid;
    logic                  am_level;

    // --------------------------------------------------
    // Control and status
    // --------------------------------------------------

    hf_rx_ctrl i_ctrl (
        .adc_clk    (adc_clk),
        .rst_n      (rst_n),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .pair       (pair),
        .pair_valid (pair_valid),
        .mode       (mode),
        .pwr_hi     (pwr_hi)
    );

    // --------------------------------------------------
    // Datapath
    // --------------------------------------------------

    am_hysteresis #(.LOW_TIMEOUT(LOW_TIMEOUT)) i_am_hyst (
        .adc_clk  (adc_clk),
        .rst_n    (rst_n),
        .mode     (mode),
        .adc_d    (adc_d),
        .am_level (am_level)
    );

    iq_correlator #(.ACC_W(ACC_W)) i_corr (
        .adc_clk    (adc_clk),
        .rst_n      (rst_n),
        .mode       (mode),
        .adc_d      (adc_d),
        .am_level   (am_level),
        .phase      (phase),
        .pair       (pair),
        .pair_valid (pair_valid)
    );

    ssp_serializer i_ssp (
        .adc_clk   (adc_clk),
        .rst_n     (rst_n),
        .mode      (mode),
        .phase     (phase),
        .pair      (pair),
        .ssp_clk   (ssp_clk),
        .ssp_frame (ssp_frame),
        .ssp_din   (ssp_din)
    );

endmodule

/* rtl/ssp_serializer.sv */
/*
 * SSP-style serializer, 16 bits per window at one bit per 4 steps.
 * Two 8-bit frames go out, i then q, most significant bit first.
 * The receiver samples data on the falling ssp_clk and cannot stall.
 */

`timescale 1ns/100ps

module ssp_serializer (
    input  logic                  adc_clk,
    input  logic                  rst_n,
    input  hf_rx_pkg::rx_mode_t   mode,
    input  hf_rx_pkg::win_phase_t phase,
    input  hf_rx_pkg::corr_pair_t pair,
    output logic                  ssp_clk,
    output logic                  ssp_frame,
    output logic                  ssp_din
);

    logic [hf_rx_pkg::PAIR_W-1:0] shreg;
    logic                         load_q;
    logic                         rise_step;
    logic                         fall_step;
    logic                         frame_step;

    // --------------------------------------------------
    // Step decode
    // --------------------------------------------------

    assign rise_step = (phase.step[1:0] == 2'b00);
    assign fall_step = (phase.step[1:0] == 2'b10);

    // Steps 0..3 open the i frame, steps 32..35 open the q frame
    assign frame_step = (phase.step[5:2] == 4'b0000) || (phase.step[5:2] == 4'b1000);

    // --------------------------------------------------
    // Serial clock, frame and shift register
    // --------------------------------------------------

    always_ff @(posedge adc_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ssp_clk   <= 1'b0;
            ssp_frame <= 1'b0;
            load_q    <= 1'b0;
            shreg     <= '0;
        end
        else if (!mode.enable)
        begin
            // Idle bus while the datapath is stopped
            ssp_clk   <= 1'b0;
            ssp_frame <= 1'b0;
            load_q    <= 1'b0;
            shreg     <= '0;
        end
        else
        begin
            // The pair registered at the step-0 edge is on the port one
            // cycle later, which is never a shift cycle, so it loads then
            load_q <= phase.step_en && (phase.step == '0);
            if (load_q)
                shreg <= pair;

            if (phase.step_en)
            begin
                ssp_frame <= frame_step;
                if (rise_step)
                begin
                    ssp_clk <= 1'b1;
                    // Step 0 brings a fresh word, so no shift there
                    if (phase.step != '0)
                        shreg <= {shreg[hf_rx_pkg::PAIR_W-2:0], 1'b0};
                end
                else if (fall_step)
                begin
                    ssp_clk <= 1'b0;
                end
            end
        end
    end

    // Data is stable across the falling edge of ssp_clk
    assign ssp_din = shreg[hf_rx_pkg::PAIR_W-1];

endmodule

/* rtl/iq_correlator.sv */
/*
 * I/Q correlator over a 64-step window against square references.
 * ACC_W must be at least 9; the report takes the top 8 accumulator bits,
 * or the top 7 plus the AM level in snoop mode.
 */

`timescale 1ns/100ps

module iq_correlator #(
    parameter int ACC_W = 14
) (
    input  logic                  adc_clk,
    input  logic                  rst_n,
    input  hf_rx_pkg::rx_mode_t   mode,
    input  hf_rx_pkg::sample_t    adc_d,
    input  logic                  am_level,
    output hf_rx_pkg::win_phase_t phase,
    output hf_rx_pkg::corr_pair_t pair,
    output logic                  pair_valid
);

    logic                           half_q;
    logic                           step_en;
    logic                           win_end;
    logic [hf_rx_pkg::STEP_W-1:0]   step_q;
    logic signed [ACC_W-1:0]        samp_ext;
    logic signed [ACC_W-1:0]        acc_i;
    logic signed [ACC_W-1:0]        acc_q;
    logic                           am_mid;
    logic                           am_end;

    // --------------------------------------------------
    // Window phase
    // --------------------------------------------------

    // Toggles every cycle so that 424 kHz mode steps on alternate cycles
    always_ff @(posedge adc_clk or negedge rst_n)
    begin
        if (!rst_n)
            half_q <= 1'b0;
        else if (!mode.enable)
            half_q <= 1'b0;
        else
            half_q <= ~half_q;
    end

    assign step_en = mode.enable && (mode.sub_848 || half_q);
    assign win_end = step_en && (step_q == '0);

    always_ff @(posedge adc_clk or negedge rst_n)
    begin
        if (!rst_n)
            step_q <= '0;
        else if (!mode.enable)
            step_q <= '0;
        else if (step_en)
            step_q <= step_q + 1'b1;
    end

    assign phase.step    = step_q;
    assign phase.step_en = step_en;

    // --------------------------------------------------
    // Accumulators
    // --------------------------------------------------

    // Sample is unsigned, so it is zero extended before the signed sum
    assign samp_ext = {{(ACC_W-hf_rx_pkg::SAMPLE_W){1'b0}}, adc_d};

    // I reference flips every 8 steps, Q is the same square shifted by 4
    always_ff @(posedge adc_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            acc_i <= '0;
            acc_q <= '0;
        end
        else if (!mode.enable)
        begin
            acc_i <= '0;
            acc_q <= '0;
        end
        else if (win_end)
        begin
            // Step 0 has a positive weight on both references
            acc_i <= samp_ext;
            acc_q <= samp_ext;
        end
        else if (step_en)
        begin
            acc_i <= step_q[3] ? acc_i - samp_ext : acc_i + samp_ext;
            acc_q <= (step_q[3] == step_q[2]) ? acc_q + samp_ext : acc_q - samp_ext;
        end
    end

    // --------------------------------------------------
    // AM samples for snoop reports
    // --------------------------------------------------

    // am_mid is taken at mid window, am_end at each window end
    always_ff @(posedge adc_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            am_mid <= 1'b0;
            am_end <= 1'b0;
        end
        else
        begin
            if (step_en && (step_q == 6'd31))
                am_mid <= am_level;
            if (win_end)
                am_end <= am_level;
        end
    end

    // --------------------------------------------------
    // Report
    // --------------------------------------------------

    // The i LSB reads am_end before it is overwritten on this edge
    always_ff @(posedge adc_clk)
    begin
        if (win_end)
        begin
            if (mode.snoop)
            begin
                pair.i <= {acc_i[ACC_W-1 -: 7], am_end};
                pair.q <= {acc_q[ACC_W-1 -: 7], am_mid};
            end
            else
            begin
                pair.i <= acc_i[ACC_W-1 -: 8];
                pair.q <= acc_q[ACC_W-1 -: 8];
            end
        end
    end

    // Strobe lines up with the new pair on the port
    always_ff @(posedge adc_clk or negedge rst_n)
    begin
        if (!rst_n)
            pair_valid <= 1'b0;
        else
            pair_valid <= win_end;
    end

endmodule

/* rtl/am_hysteresis.sv */
/*
 * Hysteresis slicer for reader AM seen in snoop mode.
 * Only full-scale samples move the level. A long low run is released after
 * LOW_TIMEOUT cycles, which must fit in 12 bits.
 */

`timescale 1ns/100ps

module am_hysteresis #(
    parameter int LOW_TIMEOUT = 4095
) (
    input  logic                adc_clk,
    input  logic                rst_n,
    input  hf_rx_pkg::rx_mode_t mode,
    input  hf_rx_pkg::sample_t  adc_d,
    output logic                am_level
);

    localparam logic [11:0] TIMEOUT_CNT = 12'(LOW_TIMEOUT);

    // Consecutive cycles spent low
    logic [11:0] low_cnt;

    always_ff @(posedge adc_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            am_level <= 1'b1;
            low_cnt  <= '0;
        end
        else if (mode.enable)
        begin
            // Clipped high means carrier on, clipped low means a reader gap
            if (&adc_d)
                am_level <= 1'b1;
            else if (~|adc_d)
                am_level <= 1'b0;

            // The timeout wins over the sample so a stuck low always ends
            if (am_level)
            begin
                low_cnt <= '0;
            end
            else if (low_cnt == TIMEOUT_CNT)
            begin
                low_cnt  <= '0;
                am_level <= 1'b1;
            end
            else
            begin
                low_cnt <= low_cnt + 1'b1;
            end
        end
    end

endmodule

/* rtl/hf_rx_ctrl.sv */
/*
 * APB register block for the receiver.
 * Writes land at the access-phase edge, reads are combinational, and pready
 * is tied high. Writes to the read-only offsets are dropped without error.
 */

`timescale 1ns/100ps

module hf_rx_ctrl (
    input  logic                  adc_clk,
    input  logic                  rst_n,
    input  hf_apb_pkg::apb_req_t  apb_req,
    output hf_apb_pkg::apb_rsp_t  apb_rsp,
    input  hf_rx_pkg::corr_pair_t pair,
    input  logic                  pair_valid,
    output hf_rx_pkg::rx_mode_t   mode,
    output logic                  pwr_hi
);

    logic                           ctrl_wr;
    logic                           bad_addr;
    logic [hf_apb_pkg::APB_DW-1:0]  rd_data;
    logic [hf_apb_pkg::COUNT_W-1:0] win_cnt;
    hf_rx_pkg::corr_pair_t          last_pair;

    // --------------------------------------------------
    // Write side
    // --------------------------------------------------

    // Only CTRL is writable
    assign ctrl_wr = apb_req.psel && apb_req.penable && apb_req.pwrite &&
                     (apb_req.paddr == hf_apb_pkg::REG_CTRL);

    always_ff @(posedge adc_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mode <= '0;
        end
        else if (ctrl_wr)
        begin
            // Bit 0 enable, bit 1 snoop, bit 2 sub_848
            mode <= hf_rx_pkg::rx_mode_t'(apb_req.pwdata[2:0]);
        end
    end

    // Carrier stays on while receiving, and goes off in snoop mode
    // so that another reader's field can be observed
    always_ff @(posedge adc_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pwr_hi <= 1'b0;
        end
        else
        begin
            pwr_hi <= mode.enable && !mode.snoop;
        end
    end

    // --------------------------------------------------
    // Status registers
    // --------------------------------------------------

    // Window count wraps at 16 bits; the pair is held for software
    always_ff @(posedge adc_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            win_cnt   <= '0;
            last_pair <= '0;
        end
        else if (pair_valid)
        begin
            win_cnt   <= win_cnt + 1'b1;
            last_pair <= pair;
        end
    end

    // --------------------------------------------------
    // Read side
    // --------------------------------------------------

    always_comb
    begin
        rd_data  = '0;
        bad_addr = 1'b0;
        case (apb_req.paddr)
            hf_apb_pkg::REG_CTRL:  rd_data[2:0] = mode;
            hf_apb_pkg::REG_COUNT: rd_data[hf_apb_pkg::COUNT_W-1:0] = win_cnt;
            hf_apb_pkg::REG_PAIR:  rd_data[hf_rx_pkg::PAIR_W-1:0] = last_pair;
            default:               bad_addr = 1'b1;
        endcase
    end

    // Error is flagged only in the access phase of a transfer
    always_comb
    begin
        apb_rsp.prdata  = rd_data;
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = apb_req.psel && apb_req.penable && bad_addr;
    end

endmodule

/* rtl/hf_apb_pkg.sv */
/*
 * APB bus types and register map of the receiver control block.
 * Only a 4-bit offset is decoded, and transfers have no wait states.
 */

package hf_apb_pkg;

    localparam int APB_AW  = 4;
    localparam int APB_DW  = 32;
    localparam int COUNT_W = 16;

    // Register offsets
    localparam logic [APB_AW-1:0] REG_CTRL  = 4'h0;
    localparam logic [APB_AW-1:0] REG_COUNT = 4'h4;
    localparam logic [APB_AW-1:0] REG_PAIR  = 4'h8;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_AW-1:0] paddr;
        logic [APB_DW-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DW-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

endpackage

/* rtl/hf_rx_pkg.sv */
/*
 * Datapath types for the HF receive correlator.
 * A window is 64 steps wide, and a report is one signed I/Q byte pair.
 */

package hf_rx_pkg;

    // --------------------------------------------------
    // Sizes
    // --------------------------------------------------

    // Width of one ADC sample
    localparam int SAMPLE_W = 8;

    // Step counter width, which gives 64 steps per window
    localparam int STEP_W = 6;

    // Bits in one serial report, i then q
    localparam int PAIR_W = 16;

    // --------------------------------------------------
    // Types
    // --------------------------------------------------

    // Raw unsigned ADC sample
    typedef logic [SAMPLE_W-1:0] sample_t;

    // Bit order matches the CTRL register layout
    typedef struct packed {
        logic sub_848;
        logic snoop;
        logic enable;
    } rx_mode_t;

    // Window position and step strobe
    typedef struct packed {
        logic [STEP_W-1:0] step;
        logic              step_en;
    } win_phase_t;

    // The i byte sits in the upper half and goes out first
    typedef struct packed {
        logic signed [7:0] i;
        logic signed [7:0] q;
    } corr_pair_t;

endpackage
